//--- Makefile
LOG = sim.log

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module aluTb -f sim.f
	./obj_dir/ValuTb > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failures found" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

//--- hdl/aluCore.sv
/*
 * Integer execution unit top: op class decode, lane arithmetic,
 * compares and logic, multiplier and divider, result and exception select
 */
`timescale 1ns/10ps
`include "alu_defines.svh"

module aluCore import aluPkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  logic       ld,
    input  logic       abort,
    input  aluOpT      op,
    input  laneSizeT   laneSize,
    input  dataT       a,
    input  dataT       b,
    input  dataT       c,
    input  logic [2:0] excEn,
    output dataT       o,
    output logic       done,
    output logic       idle,
    output excT        exc
);

localparam int W = `DATA_WIDTH;

logic isMul, isDiv, isSgn;
dataT sumLane [4];     // Indexed by laneSize
dataT diffLane [4];
dataT minLane [4];
dataT maxLane [4];
logic ltS, ltU, eq;
logic [2*W-1:0] prod;
dataT quot, rem;
logic divByZero;
logic mulDone, mulIdle, divDone, divIdle;
logic addOvf, mulOvf;

assign isMul = op inside {MUL, MULU, MULH, MULHU};
assign isDiv = op inside {DIV, DIVU, MOD, MODU};
assign isSgn = op inside {MUL, MULH, DIV, MOD};

// ======================================================================
// Datapath units
// ======================================================================
laneArith #(.laneT(byteT)) lane8 (.a(a), .b(b), .sum(sumLane[0]), .diff(diffLane[0]),
    .minOut(minLane[0]), .maxOut(maxLane[0]));
laneArith #(.laneT(halfT)) lane16 (.a(a), .b(b), .sum(sumLane[1]), .diff(diffLane[1]),
    .minOut(minLane[1]), .maxOut(maxLane[1]));
laneArith #(.laneT(wordT)) lane32 (.a(a), .b(b), .sum(sumLane[2]), .diff(diffLane[2]),
    .minOut(minLane[2]), .maxOut(maxLane[2]));
laneArith #(.laneT(dwordT)) lane64 (.a(a), .b(b), .sum(sumLane[3]), .diff(diffLane[3]),
    .minOut(minLane[3]), .maxOut(maxLane[3]));

multiplier mulUnit (.clk(clk), .rstN(rstN), .ld(ld && isMul), .abort(abort), .sgn(isSgn),
    .a(a), .b(b), .prod(prod), .done(mulDone), .idle(mulIdle));

divider divUnit (.clk(clk), .rstN(rstN), .ld(ld && isDiv), .abort(abort), .sgn(isSgn),
    .a(a), .b(b), .quot(quot), .rem(rem), .divByZero(divByZero),
    .done(divDone), .idle(divIdle));

// Scalar compares on the low bits of the selected size
always_comb
begin
    case (laneSize)
        LANE8:
        begin
            ltS = $signed(a[7:0]) < $signed(b[7:0]);
            ltU = a[7:0] < b[7:0];
            eq  = a[7:0] == b[7:0];
        end
        LANE16:
        begin
            ltS = $signed(a[15:0]) < $signed(b[15:0]);
            ltU = a[15:0] < b[15:0];
            eq  = a[15:0] == b[15:0];
        end
        LANE32:
        begin
            ltS = $signed(a[31:0]) < $signed(b[31:0]);
            ltU = a[31:0] < b[31:0];
            eq  = a[31:0] == b[31:0];
        end
        default:
        begin
            ltS = $signed(a) < $signed(b);
            ltU = a < b;
            eq  = a == b;
        end
    endcase
end

// ======================================================================
// Result select
// ======================================================================
always_comb
begin
    case (op)
        ADD:     o = sumLane[laneSize];
        SUB:     o = diffLane[laneSize];
        MIN:     o = minLane[laneSize];
        MAX:     o = maxLane[laneSize];
        CMP:     o = ltS ? '1 : (eq ? '0 : dataT'(1));
        CMPU:    o = ltU ? '1 : (eq ? '0 : dataT'(1));
        SEQ:     o = dataT'(eq);
        SLT:     o = dataT'(ltS);
        SLTU:    o = dataT'(ltU);
        AND:     o = a & b;
        OR:      o = a | b;
        XOR:     o = a ^ b;
        NAND:    o = ~(a & b);
        NOR:     o = ~(a | b);
        XNOR:    o = ~(a ^ b);
        CMOVEQ:  o = (a == '0) ? b : c;
        CMOVNE:  o = (a != '0) ? b : c;
        MUX:     o = (a & b) | (~a & c);   // Bit select by a
        MUL,
        MULU:    o = prod[W-1:0];
        MULH,
        MULHU:   o = prod[2*W-1:W];
        DIV,
        DIVU:    o = quot;
        MOD,
        MODU:    o = rem;
        default: o = '0;
    endcase
end

assign done = isMul ? mulDone : (isDiv ? divDone : 1'b1);
assign idle = isMul ? mulIdle : (isDiv ? divIdle : 1'b1);

// Full-width signed overflow only
assign addOvf = (laneSize == LANE64) &&
    ((op == ADD && a[W-1] == b[W-1] && sumLane[3][W-1] != a[W-1]) ||
     (op == SUB && a[W-1] != b[W-1] && diffLane[3][W-1] != a[W-1]));

assign mulOvf = (op == MUL && prod[2*W-1:W] != {W{prod[W-1]}}) ||
                (op == MULU && prod[2*W-1:W] != '0);

always_comb
begin
    if (addOvf && excEn[0])
        exc = EXC_OVERFLOW;
    else if (mulOvf && excEn[1])
        exc = EXC_OVERFLOW;
    else if (isDiv && divByZero && excEn[2])
        exc = EXC_DIVZERO;
    else
        exc = EXC_NONE;
end

endmodule

//--- hdl/aluPkg.sv
/*
 * Shared types of the execution unit: decoded operations,
 * lane sizes, exception codes and lane payload types
 */
`include "alu_defines.svh"

package aluPkg;

    // Decoded operation
    typedef enum logic [4:0]
    {
        ADD, SUB, MIN, MAX,
        CMP, CMPU, SEQ, SLT, SLTU,
        AND, OR, XOR, NAND, NOR, XNOR,
        CMOVEQ, CMOVNE, MUX,
        MUL, MULU, MULH, MULHU,
        DIV, DIVU, MOD, MODU,
        NOP
    } aluOpT;

    typedef enum logic [1:0]
    {
        LANE8  = 2'd0,
        LANE16 = 2'd1,
        LANE32 = 2'd2,
        LANE64 = 2'd3
    } laneSizeT;

    typedef enum logic [1:0]
    {
        EXC_NONE     = 2'd0,
        EXC_OVERFLOW = 2'd1,
        EXC_DIVZERO  = 2'd2
    } excT;

    typedef logic [`BYTE_WIDTH-1:0]  byteT;
    typedef logic [`HALF_WIDTH-1:0]  halfT;
    typedef logic [`WORD_WIDTH-1:0]  wordT;
    typedef logic [`DWORD_WIDTH-1:0] dwordT;

    typedef logic [`DATA_WIDTH-1:0]  dataT;

endpackage

//--- hdl/alu_defines.svh
/*
 * Operand width, lane widths and iteration counts for the execution unit
 */
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

`define DATA_WIDTH  64

// Lane payload widths
`define BYTE_WIDTH  8
`define HALF_WIDTH  16
`define WORD_WIDTH  32
`define DWORD_WIDTH (`DATA_WIDTH)

`define MUL_CYCLES  (`DATA_WIDTH)  // One shift-add step per operand bit
`define DIV_CYCLES  (`DATA_WIDTH)

`endif

//--- hdl/divider.sv
/*
 * Sequential restoring divider, signed or unsigned,
 * quotient, remainder and divide-by-zero flag
 */
`timescale 1ns/10ps
`include "alu_defines.svh"

module divider import aluPkg::*;
(
    input  logic clk,
    input  logic rstN,
    input  logic ld,
    input  logic abort,
    input  logic sgn,
    input  dataT a,
    input  dataT b,
    output dataT quot,
    output dataT rem,
    output logic divByZero,
    output logic done,
    output logic idle
);

localparam int W     = `DATA_WIDTH;
localparam int CNT_W = $clog2(`DIV_CYCLES);

logic             busy;
logic             fixStep;
logic             negQ;        // Operand signs differ
logic             negR;        // Dividend negative
logic [CNT_W-1:0] cnt;
dataT             dvsr;
dataT             aMag;
dataT             bMag;
logic [W:0]       shifted;
logic [W:0]       trial;

assign aMag = (sgn && a[W-1]) ? -a : a;
assign bMag = (sgn && b[W-1]) ? -b : b;

// Next dividend bit enters from the top of the quotient register
assign shifted = {rem, quot[W-1]};
assign trial   = shifted - {1'b0, dvsr};

always_ff @(posedge clk or negedge rstN)
begin
    if (!rstN)
    begin
        busy      <= 1'b0;
        fixStep   <= 1'b0;
        negQ      <= 1'b0;
        negR      <= 1'b0;
        cnt       <= '0;
        dvsr      <= '0;
        divByZero <= 1'b0;
        quot      <= '0;
        rem       <= '0;
    end
    else if (abort)
    begin
        busy    <= 1'b0;
        fixStep <= 1'b0;
    end
    else if (!busy)
    begin
        if (ld)
        begin
            busy      <= 1'b1;
            fixStep   <= 1'b0;
            cnt       <= '0;
            negQ      <= sgn & (a[W-1] ^ b[W-1]);
            negR      <= sgn & a[W-1];
            dvsr      <= bMag;
            divByZero <= (b == '0);
            quot      <= aMag;
            rem       <= '0;
        end
    end
    else if (fixStep)
    begin
        busy    <= 1'b0;
        fixStep <= 1'b0;
        quot    <= divByZero ? '1 : (negQ ? -quot : quot);
        rem     <= negR ? -rem : rem;   // Zero divisor leaves the dividend here
    end
    else
    begin
        if (!trial[W])
        begin
            rem  <= trial[W-1:0];
            quot <= {quot[W-2:0], 1'b1};
        end
        else
        begin
            rem  <= shifted[W-1:0];   // Restore
            quot <= {quot[W-2:0], 1'b0};
        end
        cnt <= cnt + 1'b1;
        if (cnt == CNT_W'(`DIV_CYCLES - 1))
            fixStep <= 1'b1;
    end
end

assign done = ~busy;
assign idle = ~busy;

endmodule

//--- hdl/laneArith.sv
/*
 * Lane-partitioned add, subtract, signed min and signed max,
 * lane width taken from the payload type
 */
`timescale 1ns/10ps
`include "alu_defines.svh"

module laneArith import aluPkg::*;
#(
    parameter type laneT = byteT
)
(
    input  dataT a,
    input  dataT b,
    output dataT sum,
    output dataT diff,
    output dataT minOut,
    output dataT maxOut
);

localparam int LW    = $bits(laneT);
localparam int LANES = `DATA_WIDTH / LW;

// ======================================================================
// One slice per lane
// ======================================================================
genvar i;
generate
    for (i = 0; i < LANES; i++)
    begin : gLane
        laneT la;
        laneT lb;
        logic aLess;

        assign la    = a[i*LW +: LW];
        assign lb    = b[i*LW +: LW];
        assign aLess = $signed(la) < $signed(lb);   // Signed within the lane

        // Carry and borrow stop at the lane edge
        assign sum[i*LW +: LW]  = la + lb;
        assign diff[i*LW +: LW] = la - lb;

        assign minOut[i*LW +: LW] = aLess ? la : lb;
        assign maxOut[i*LW +: LW] = aLess ? lb : la;
    end
endgenerate

endmodule

//--- hdl/multiplier.sv
/*
 * Sequential shift-add multiplier, signed or unsigned,
 * double-width product with done/idle status and abort
 */
`timescale 1ns/10ps
`include "alu_defines.svh"

module multiplier import aluPkg::*;
(
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     ld,
    input  logic                     abort,
    input  logic                     sgn,
    input  dataT                     a,
    input  dataT                     b,
    output logic [2*`DATA_WIDTH-1:0] prod,
    output logic                     done,
    output logic                     idle
);

localparam int W     = `DATA_WIDTH;
localparam int CNT_W = $clog2(`MUL_CYCLES);

logic             busy;
logic             fixStep;     // Sign correction on the next edge
logic             negRes;
logic [CNT_W-1:0] cnt;
dataT             mcand;
dataT             aMag;
dataT             bMag;
logic [W:0]       partial;

assign aMag = (sgn && a[W-1]) ? -a : a;
assign bMag = (sgn && b[W-1]) ? -b : b;

// Upper half plus multiplicand when the current multiplier bit is set
assign partial = {1'b0, prod[2*W-1:W]} + (prod[0] ? {1'b0, mcand} : '0);

always_ff @(posedge clk or negedge rstN)
begin
    if (!rstN)
    begin
        busy    <= 1'b0;
        fixStep <= 1'b0;
        negRes  <= 1'b0;
        cnt     <= '0;
        mcand   <= '0;
        prod    <= '0;
    end
    else if (abort)
    begin
        busy    <= 1'b0;
        fixStep <= 1'b0;
    end
    else if (!busy)
    begin
        if (ld)
        begin
            busy    <= 1'b1;
            fixStep <= 1'b0;
            cnt     <= '0;
            negRes  <= sgn & (a[W-1] ^ b[W-1]);
            mcand   <= aMag;
            prod    <= {{W{1'b0}}, bMag};   // Multiplier sits in the low half
        end
    end
    else if (fixStep)
    begin
        busy    <= 1'b0;
        fixStep <= 1'b0;
        if (negRes)
            prod <= -prod;
    end
    else
    begin
        prod <= {partial, prod[W-1:1]};
        cnt  <= cnt + 1'b1;
        if (cnt == CNT_W'(`MUL_CYCLES - 1))
            fixStep <= 1'b1;
    end
end

assign done = ~busy;
assign idle = ~busy;

endmodule

//--- sim.f
+incdir+hdl
hdl/aluPkg.sv
hdl/laneArith.sv
hdl/multiplier.sv
hdl/divider.sv
hdl/aluCore.sv
test/alu_checker.sv
test/aluMonitor.sv
test/aluTb.sv

//--- test/aluMonitor.sv
/*
 * Result monitor: compares o and exc with the expected values
 * on each check strobe, checks done/idle after an abort, counts errors
 */
`timescale 1ns/10ps

module aluMonitor import aluPkg::*;
(
    input  logic  clk,
    input  aluOpT op,
    input  dataT  o,
    input  excT   exc,
    input  logic  done,
    input  logic  idle,
    input  logic  chk,
    input  logic  chkIdle,
    input  dataT  expO,
    input  excT   expExc,
    input  int    assertFails,
    input  logic  report,
    output int    errCount
);

int checks = 0;
int mismatches = 0;

assign errCount = mismatches + assertFails;

always @(posedge clk)
begin
    if (chk)
    begin
        checks++;
        if (o !== expO)
        begin
            mismatches++;
            $display("FAILED at %0t ns: %s gave o = %h, expected %h",
                $time, op.name(), o, expO);
        end
        if (exc !== expExc)
        begin
            mismatches++;
            $display("FAILED at %0t ns: %s gave exc = %s, expected %s",
                $time, op.name(), exc.name(), expExc.name());
        end
    end
    if (chkIdle)
    begin
        checks++;
        if (!(done && idle))
        begin
            mismatches++;
            $display("FAILED at %0t ns: done/idle not high one edge after abort", $time);
        end
    end
end

always @(posedge report)
    $display("Checks: %0d, mismatches: %0d, assertion failures: %0d",
        checks, mismatches, assertFails);

endmodule

//--- test/aluTb.sv
/*
 * Testbench top: clock, reset, stimulus table with random multiply/divide
 * entries, abort sequence, watchdog and final verdict
 */
`timescale 1ns/10ps
`include "alu_defines.svh"

module aluTb import aluPkg::*;
();

localparam int W = `DATA_WIDTH;

logic       clk;
logic       rstN;
logic       ld;
logic       abort;
aluOpT      op;
laneSizeT   laneSize;
dataT       a, b, c;
logic [2:0] excEn;
dataT       o;
logic       done, idle;
excT        exc;

dataT expO;
excT  expExc;
logic chk, chkIdle, report, tableReady;
int   errCount;

// Stimulus table, one queue per column
aluOpT      opQ[$];
laneSizeT   lsQ[$];
dataT       aQ[$], bQ[$], cQ[$], expOQ[$];
logic [2:0] enQ[$];
excT        excQ[$];

aluCore dut (.clk(clk), .rstN(rstN), .ld(ld), .abort(abort), .op(op), .laneSize(laneSize),
    .a(a), .b(b), .c(c), .excEn(excEn), .o(o), .done(done), .idle(idle), .exc(exc));

aluMonitor mon (.clk(clk), .op(op), .o(o), .exc(exc), .done(done), .idle(idle), .chk(chk),
    .chkIdle(chkIdle), .expO(expO), .expExc(expExc),
    .assertFails(dut.protoChk.failCount), .report(report), .errCount(errCount));

always #50 clk = ~clk;

// ======================================================================
// Reference model for multiply and divide
// ======================================================================
task automatic refMulDiv(input aluOpT rop, input dataT ra, input dataT rb,
    input logic [2:0] ren, output dataT res, output excT rex);
    logic         sgn;
    logic [2*W-1:0] pa, pb, prod;
    dataT         aMag, bMag, q, r;
    sgn  = rop inside {MUL, MULH, DIV, MOD};
    pa   = sgn ? {{W{ra[W-1]}}, ra} : {{W{1'b0}}, ra};
    pb   = sgn ? {{W{rb[W-1]}}, rb} : {{W{1'b0}}, rb};
    prod = pa * pb;   // Two's complement, truncated to double width
    aMag = (sgn && ra[W-1]) ? -ra : ra;
    bMag = (sgn && rb[W-1]) ? -rb : rb;
    if (rb == '0)
    begin
        q = '1;
        r = ra;
    end
    else
    begin
        q = aMag / bMag;
        r = aMag % bMag;
        if (sgn && (ra[W-1] != rb[W-1]))
            q = -q;
        if (sgn && ra[W-1])
            r = -r;   // Remainder follows the dividend
    end
    rex = EXC_NONE;
    case (rop)
        MUL:     res = prod[W-1:0];
        MULU:    res = prod[W-1:0];
        MULH,
        MULHU:   res = prod[2*W-1:W];
        DIV,
        DIVU:    res = q;
        default: res = r;
    endcase
    // Product does not fit in one word
    if (ren[1] && rop == MUL && prod != {{W{prod[W-1]}}, prod[W-1:0]})
        rex = EXC_OVERFLOW;
    if (ren[1] && rop == MULU && prod != {{W{1'b0}}, prod[W-1:0]})
        rex = EXC_OVERFLOW;
    if (ren[2] && (rop inside {DIV, DIVU, MOD, MODU}) && rb == '0)
        rex = EXC_DIVZERO;
endtask

task automatic addEntry(input aluOpT eop, input laneSizeT els, input dataT ea,
    input dataT eb, input dataT ec, input logic [2:0] een, input dataT eo, input excT eex);
    opQ.push_back(eop);
    lsQ.push_back(els);
    aQ.push_back(ea);
    bQ.push_back(eb);
    cQ.push_back(ec);
    enQ.push_back(een);
    expOQ.push_back(eo);
    excQ.push_back(eex);
endtask

task automatic buildTable();
    dataT       x, y, z, ro;
    excT        rex;
    aluOpT      rop;
    logic [2:0] ren;
    aluOpT      mdOps[8] = '{MUL, MULU, MULH, MULHU, DIV, DIVU, MOD, MODU};
    x = 64'h01FF_7F80_FFFF_0001;   // Carries that must stop at lane edges
    y = 64'h0101_0180_0001_00FF;
    addEntry(ADD, LANE8, x, y, '0, '0, 64'h0200_8000_FF00_0000, EXC_NONE);
    addEntry(ADD, LANE16, x, y, '0, '0, 64'h0300_8100_0000_0100, EXC_NONE);
    addEntry(ADD, LANE32, x, y, '0, '0, 64'h0300_8100_0000_0100, EXC_NONE);
    addEntry(ADD, LANE64, x, y, '0, '0, 64'h0300_8101_0000_0100, EXC_NONE);
    x = 64'h100;
    y = 64'h1;
    addEntry(SUB, LANE8, x, y, '0, '0, 64'h1FF, EXC_NONE);
    addEntry(SUB, LANE64, x, y, '0, '0, 64'hFF, EXC_NONE);
    x = 64'h1_0000_0000;
    addEntry(SUB, LANE16, x, y, '0, '0, 64'h1_0000_FFFF, EXC_NONE);
    addEntry(SUB, LANE32, x, y, '0, '0, 64'h1_FFFF_FFFF, EXC_NONE);
    x = 64'h807F;
    y = 64'h7F80;
    addEntry(MIN, LANE8, x, y, '0, '0, 64'h8080, EXC_NONE);
    addEntry(MAX, LANE8, x, y, '0, '0, 64'h7F7F, EXC_NONE);
    addEntry(MIN, LANE16, x, y, '0, '0, 64'h807F, EXC_NONE);
    addEntry(MAX, LANE16, x, y, '0, '0, 64'h7F80, EXC_NONE);
    addEntry(MIN, LANE32, x, y, '0, '0, 64'h7F80, EXC_NONE);
    addEntry(MAX, LANE32, x, y, '0, '0, 64'h807F, EXC_NONE);
    addEntry(MIN, LANE64, x, y, '0, '0, 64'h7F80, EXC_NONE);
    addEntry(MAX, LANE64, x, y, '0, '0, 64'h807F, EXC_NONE);
    // Compares, operands differ only above the small sizes
    x = 64'hFF00_0000_0000_0005;
    y = 64'h5;
    addEntry(CMP, LANE8, x, y, '0, '0, '0, EXC_NONE);
    addEntry(SEQ, LANE8, x, y, '0, '0, 64'h1, EXC_NONE);
    addEntry(CMP, LANE64, x, y, '0, '0, '1, EXC_NONE);
    addEntry(CMPU, LANE64, x, y, '0, '0, 64'h1, EXC_NONE);
    addEntry(SLT, LANE64, x, y, '0, '0, 64'h1, EXC_NONE);
    addEntry(SLTU, LANE64, x, y, '0, '0, '0, EXC_NONE);
    x = 64'h0180;
    y = 64'h7F;
    addEntry(CMP, LANE8, x, y, '0, '0, '1, EXC_NONE);
    addEntry(CMPU, LANE8, x, y, '0, '0, 64'h1, EXC_NONE);
    addEntry(SLT, LANE8, x, y, '0, '0, 64'h1, EXC_NONE);
    addEntry(SLTU, LANE8, x, y, '0, '0, '0, EXC_NONE);
    x = 64'h1_8000;
    y = 64'h7FFF;
    addEntry(CMP, LANE16, x, y, '0, '0, '1, EXC_NONE);
    addEntry(CMPU, LANE16, x, y, '0, '0, 64'h1, EXC_NONE);
    addEntry(SLT, LANE16, x, y, '0, '0, 64'h1, EXC_NONE);
    addEntry(SLTU, LANE16, x, y, '0, '0, '0, EXC_NONE);
    addEntry(CMP, LANE32, x, y, '0, '0, 64'h1, EXC_NONE);
    x = 64'h1_8000_0000;
    y = 64'h7FFF_FFFF;
    addEntry(CMPU, LANE32, x, y, '0, '0, 64'h1, EXC_NONE);
    addEntry(SLT, LANE32, x, y, '0, '0, 64'h1, EXC_NONE);
    addEntry(SLTU, LANE32, x, y, '0, '0, '0, EXC_NONE);
    x = 64'h0000_0001_0000_0003;
    y = 64'h3;
    addEntry(SEQ, LANE16, x, y, '0, '0, 64'h1, EXC_NONE);
    addEntry(SEQ, LANE32, x, y, '0, '0, 64'h1, EXC_NONE);
    addEntry(SEQ, LANE64, x, y, '0, '0, '0, EXC_NONE);
    // Logic, moves and bit select
    x = 64'hF0F0_F0F0_F0F0_F0F0;
    y = 64'hFF00_FF00_FF00_FF00;
    z = 64'h1234_5678_9ABC_DEF0;
    addEntry(AND, LANE64, x, y, z, '0, 64'hF000_F000_F000_F000, EXC_NONE);
    addEntry(OR, LANE64, x, y, z, '0, 64'hFFF0_FFF0_FFF0_FFF0, EXC_NONE);
    addEntry(XOR, LANE64, x, y, z, '0, 64'h0FF0_0FF0_0FF0_0FF0, EXC_NONE);
    addEntry(NAND, LANE64, x, y, z, '0, 64'h0FFF_0FFF_0FFF_0FFF, EXC_NONE);
    addEntry(NOR, LANE64, x, y, z, '0, 64'h000F_000F_000F_000F, EXC_NONE);
    addEntry(XNOR, LANE64, x, y, z, '0, 64'hF00F_F00F_F00F_F00F, EXC_NONE);
    addEntry(MUX, LANE64, x, y, z, '0, 64'hF204_F608_FA0C_FE00, EXC_NONE);
    addEntry(CMOVEQ, LANE64, '0, 64'h1111, 64'h2222, '0, 64'h1111, EXC_NONE);
    addEntry(CMOVEQ, LANE64, 64'h5, 64'h1111, 64'h2222, '0, 64'h2222, EXC_NONE);
    addEntry(CMOVNE, LANE64, 64'h5, 64'h1111, 64'h2222, '0, 64'h1111, EXC_NONE);
    addEntry(CMOVNE, LANE64, '0, 64'h1111, 64'h2222, '0, 64'h2222, EXC_NONE);
    // Add/sub overflow, enabled and masked
    x = 64'h7FFF_FFFF_FFFF_FFFF;
    y = 64'h1;
    addEntry(ADD, LANE64, x, y, '0, 3'b001, 64'h8000_0000_0000_0000, EXC_OVERFLOW);
    addEntry(ADD, LANE64, x, y, '0, 3'b000, 64'h8000_0000_0000_0000, EXC_NONE);
    addEntry(ADD, LANE32, x, y, '0, 3'b001, 64'h7FFF_FFFF_0000_0000, EXC_NONE);
    addEntry(SUB, LANE64, ~x, y, '0, 3'b001, x, EXC_OVERFLOW);
    // Multiply
    addEntry(MUL, LANE64, -64'd3, 64'd5, '0, 3'b010, -64'd15, EXC_NONE);
    addEntry(MULH, LANE64, -64'd3, 64'd5, '0, '0, '1, EXC_NONE);
    addEntry(MULU, LANE64, '1, 64'd2, '0, 3'b010, -64'd2, EXC_OVERFLOW);
    addEntry(MULU, LANE64, '1, 64'd2, '0, 3'b000, -64'd2, EXC_NONE);
    addEntry(MULHU, LANE64, '1, 64'd2, '0, '0, 64'd1, EXC_NONE);
    x = 64'h4000_0000_0000_0000;
    addEntry(MUL, LANE64, x, 64'd4, '0, 3'b010, '0, EXC_OVERFLOW);
    addEntry(MUL, LANE64, x, 64'd4, '0, 3'b000, '0, EXC_NONE);
    addEntry(MULH, LANE64, x, 64'd4, '0, '0, 64'd1, EXC_NONE);
    // Divide, signed and by zero
    addEntry(DIV, LANE64, -64'd7, 64'd2, '0, '0, -64'd3, EXC_NONE);
    addEntry(MOD, LANE64, -64'd7, 64'd2, '0, '0, '1, EXC_NONE);
    addEntry(DIV, LANE64, 64'd7, -64'd2, '0, '0, -64'd3, EXC_NONE);
    addEntry(MOD, LANE64, 64'd7, -64'd2, '0, '0, 64'd1, EXC_NONE);
    addEntry(DIVU, LANE64, 64'd100, 64'd7, '0, '0, 64'd14, EXC_NONE);
    addEntry(MODU, LANE64, 64'd100, 64'd7, '0, '0, 64'd2, EXC_NONE);
    addEntry(DIVU, LANE64, 64'h1234, '0, '0, 3'b100, '1, EXC_DIVZERO);
    addEntry(MODU, LANE64, 64'h1234, '0, '0, 3'b000, 64'h1234, EXC_NONE);
    addEntry(MODU, LANE64, 64'h1234, '0, '0, 3'b100, 64'h1234, EXC_DIVZERO);
    addEntry(DIV, LANE64, -64'd5, '0, '0, 3'b100, '1, EXC_DIVZERO);
    addEntry(MOD, LANE64, -64'd5, '0, '0, 3'b000, -64'd5, EXC_NONE);
    for (int i = 0; i < 20; i++)
    begin
        rop = mdOps[$urandom % 8];
        x   = {$urandom, $urandom};
        y   = {$urandom, $urandom} >> ($urandom % W);
        if ($urandom % 6 == 0)
            y = '0;
        ren = 3'($urandom);
        refMulDiv(rop, x, y, ren, ro, rex);
        addEntry(rop, LANE64, x, y, '0, ren, ro, rex);
    end
    addEntry(MUL, LANE64, 64'd6, 64'd7, '0, 3'b010, 64'd42, EXC_NONE);   // After the abort
endtask

// Called 1 ns after a rising edge
task automatic applyEntry(input int i);
    op       = opQ[i];
    laneSize = lsQ[i];
    a        = aQ[i];
    b        = bQ[i];
    c        = cQ[i];
    excEn    = enQ[i];
    expO     = expOQ[i];
    expExc   = excQ[i];
    if (op inside {MUL, MULU, MULH, MULHU, DIV, DIVU, MOD, MODU})
    begin
        ld = 1'b1;
        @(posedge clk);
        #1;
        ld = 1'b0;
        while (!done)
        begin
            @(posedge clk);
            #1;
        end
    end
    chk = 1'b1;
    @(posedge clk);
    #1;
    chk = 1'b0;
endtask

task automatic abortMidMul();
    op    = MUL;
    a     = 64'h0123_4567_89AB_CDEF;
    b     = 64'hFEDC_BA98_7654_3210;
    excEn = '0;
    ld    = 1'b1;
    @(posedge clk);
    #1;
    ld = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    abort = 1'b1;
    @(posedge clk);
    #1;
    abort   = 1'b0;
    chkIdle = 1'b1;   // Sees the state left by the abort edge
    @(posedge clk);
    #1;
    chkIdle = 1'b0;
endtask

// ======================================================================
// Main sequence and watchdog
// ======================================================================
initial
begin
    void'($urandom(71199));
    clk        = 1'b0;
    rstN       = 1'b0;
    ld         = 1'b0;
    abort      = 1'b0;
    op         = NOP;
    laneSize   = LANE64;
    a          = '0;
    b          = '0;
    c          = '0;
    excEn      = '0;
    expO       = '0;
    expExc     = EXC_NONE;
    chk        = 1'b0;
    chkIdle    = 1'b0;
    report     = 1'b0;
    tableReady = 1'b0;
    buildTable();
    tableReady = 1'b1;
    repeat (16) @(posedge clk);
    #1;
    rstN = 1'b1;
    @(posedge clk);
    #1;
    for (int i = 0; i < opQ.size() - 1; i++)
        applyEntry(i);
    abortMidMul();
    applyEntry(opQ.size() - 1);
    report = 1'b1;
    #1;
    if (errCount == 0)
        $display("All tests passed!");
    else
        $display("Test failures found");
    $finish;
end

initial
begin
    wait (tableReady);
    repeat (opQ.size() * (`DIV_CYCLES + 4) + 40) @(posedge clk);
    $display("Timeout: the run did not complete within the cycle budget");
    $display("Test failures found");
    $finish;
end

endmodule

//--- test/alu_checker.sv
/*
 * Protocol assertions for the execution unit, bound into aluCore
 */
`timescale 1ns/10ps
`include "alu_defines.svh"

module aluChecker
(
    input logic clk,
    input logic rstN,
    input logic ld,
    input logic abort,
    input logic isMul,
    input logic isDiv,
    input logic mulDone,
    input logic mulIdle,
    input logic divDone,
    input logic divIdle,
    input logic done,
    input logic idle
);

int failCount = 0;

// Both units come out of reset ready
assert property (@(posedge clk) $rose(rstN) |-> (mulDone && mulIdle && divDone && divIdle))
else
begin
    $error("multiplier or divider not ready right after reset");
    failCount++;
end

// Fixed latency, counted in sampled edges after the load edge
assert property (@(posedge clk) disable iff (!rstN || abort)
    (ld && isMul && idle) |=> !done [*(`MUL_CYCLES + 1)] ##1 done)
else
begin
    $error("multiply done at the wrong edge");
    failCount++;
end

assert property (@(posedge clk) disable iff (!rstN || abort)
    (ld && isDiv && idle) |=> !done [*(`DIV_CYCLES + 1)] ##1 done)
else
begin
    $error("divide done at the wrong edge");
    failCount++;
end

endmodule

bind aluCore aluChecker protoChk (.*);
